//--- Makefile
# Verilator build and run for the FPU testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FLIST)) src/fpu_defines.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 8, // clock period in time units
    parameter int RST_CYCLES = 5  // cycles with rst_n held low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // free running
    end

    initial begin
        rst_n = 1'b0; // low from time zero
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge
    end

endmodule

`default_nettype wire

//--- sim/tb_fpu.sv
`default_nettype none

`include "fpu_defines.svh"

module tb_fpu;

    localparam int ACK_LIMIT  = 10;  // cycles to wait for wb_ack
    localparam int POLL_LIMIT = 60;  // stat reads before giving up
    localparam int RST_LIMIT  = 20;  // cycles to wait for reset release
    localparam int N_RANDOM   = 200;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [1:0]  op;       // 0 add, 1 eq, 2 lt, 3 le
        logic [31:0] expected; // add result or flag in bit 0
    } vec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`FPU_ADR_W-1:0]  wb_adr;
    logic [`FPU_DATA_W-1:0] wb_dat_i;
    logic [`FPU_DATA_W-1:0] wb_dat_o;
    logic                   wb_ack;

    vec_t        vecs[$];  // directed table
    logic [31:0] last_res; // last add result expected in RES

    tb_clkgen #(.PERIOD(8), .RST_CYCLES(5)) i_clkgen (.clk(clk), .rst_n(rst_n));

    fpu_top i_dut (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            fail_run("stopping on a wrong value");
        end
    endtask

    // one classic cycle with the request held until ack and then dropped
    task automatic bus_cycle(input logic we, input logic [`FPU_ADR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cnt;
        cnt = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        do begin
            @(negedge clk); // outputs settled mid cycle
            cnt++;
            if (!wb_ack && cnt > ACK_LIMIT)
                fail_run("bus access timed out waiting for wb_ack");
        end while (!wb_ack);
        rdata = wb_dat_o; // valid while ack high
        check_value("ack latency in cycles", cnt, 32'd2);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_value("ack still high after one cycle", {31'b0, wb_ack}, 32'd0);
    endtask

    task automatic wb_write(input logic [`FPU_ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`FPU_ADR_W-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    // poll stat until busy drops and hand back the last stat word
    task automatic wait_idle(output logic [31:0] stat);
        int polls;
        polls = 0;
        do begin
            wb_read(`FPU_REG_STAT, stat);
            polls++;
            if (stat[0] && polls > POLL_LIMIT)
                fail_run("operation still busy after the poll limit");
        end while (stat[0]);
    endtask

    // sign decides first and magnitude order flips when both are negative
    function automatic logic compare_model(input logic [31:0] a, input logic [31:0] b,
                                           input logic [1:0] op);
        logic [30:0] ma;
        logic [30:0] mb;
        logic        less;
        logic        less_eq;
        ma = a[30:0]; // exp and mant as one magnitude
        mb = b[30:0];
        if (a[31] != b[31]) begin
            less    = a[31];
            less_eq = a[31];
        end else if (a[31]) begin
            less    = mb < ma;
            less_eq = mb <= ma;
        end else begin
            less    = ma < mb;
            less_eq = ma <= mb;
        end
        case (op)
            2'd1:    return a == b;
            2'd2:    return less;
            2'd3:    return less_eq;
            default: return 1'b0;
        endcase
    endfunction

    task automatic run_op(input vec_t v);
        logic [31:0] stat;
        logic [31:0] res;
        wb_write(`FPU_REG_A, v.a);
        wb_write(`FPU_REG_B, v.b);
        wb_write(`FPU_REG_CTRL, {30'b0, v.op});
        if (v.op == 2'd0) begin
            wb_read(`FPU_REG_STAT, stat);
            check_value("busy right after add start", {31'b0, stat[0]}, 32'd1);
        end
        wait_idle(stat);
        wb_read(`FPU_REG_RES, res);
        if (v.op == 2'd0) begin
            check_value("add result", res, v.expected);
            last_res = v.expected;
        end else begin
            check_value("compare flag", {31'b0, stat[1]}, v.expected);
            check_value("RES kept across compare", res, last_res);
        end
    endtask

    initial begin
        vec_t        v;
        logic [31:0] rd;
        logic [31:0] rnd;
        int          cnt;
        wb_cyc   <= 1'b0; // bus idle from time zero
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_i <= '0;
        last_res = 32'h0;
        void'($urandom(32'h817d));

        // exact adds with 0.25 left in RES by the last one
        vecs.push_back('{32'h3fc00000, 32'h40100000, 2'd0, 32'h40700000}); // 1.5+2.25
        vecs.push_back('{32'h3fc00000, 32'h3fc00000, 2'd0, 32'h40400000}); // carry out
        vecs.push_back('{32'h40a00000, 32'hc0a00000, 2'd0, 32'h00000000}); // 5-5 gives +0
        vecs.push_back('{32'h40400000, 32'hbf800000, 2'd0, 32'h40000000}); // 3-1
        vecs.push_back('{32'h3fe00000, 32'hbfc00000, 2'd0, 32'h3e800000}); // two left shifts
        // compares
        vecs.push_back('{32'h3fc00000, 32'h3fc00000, 2'd1, 32'd1});
        vecs.push_back('{32'h3fc00000, 32'hbfc00000, 2'd1, 32'd0}); // sign only differs
        vecs.push_back('{32'h3fc00001, 32'h3fc00000, 2'd1, 32'd0}); // lsb differs
        vecs.push_back('{32'h3fc00000, 32'h40100000, 2'd2, 32'd1}); // both positive
        vecs.push_back('{32'h40100000, 32'h3fc00000, 2'd2, 32'd0});
        vecs.push_back('{32'hc0100000, 32'hbfc00000, 2'd2, 32'd1}); // -2.25 < -1.5
        vecs.push_back('{32'hbfc00000, 32'hc0100000, 2'd2, 32'd0});
        vecs.push_back('{32'hbf800000, 32'h40400000, 2'd2, 32'd1}); // mixed sign
        vecs.push_back('{32'h40400000, 32'hbf800000, 2'd2, 32'd0});
        vecs.push_back('{32'h3fc00000, 32'h3fc00000, 2'd2, 32'd0}); // equal so not lt
        vecs.push_back('{32'h3fc00000, 32'h3fc00000, 2'd3, 32'd1});
        vecs.push_back('{32'hbfc00000, 32'hbfc00000, 2'd3, 32'd1});
        vecs.push_back('{32'h40100000, 32'h3fc00000, 2'd3, 32'd0});
        vecs.push_back('{32'hbfc00000, 32'hc0100000, 2'd3, 32'd0});
        vecs.push_back('{32'hbf800000, 32'h40400000, 2'd3, 32'd1});

        cnt = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cnt++;
            if (rst_n !== 1'b1 && cnt > RST_LIMIT)
                fail_run("reset never released");
        end

        wb_read(`FPU_REG_STAT, rd);
        check_value("STAT after reset", rd, 32'h0);
        wb_read(`FPU_REG_RES, rd);
        check_value("RES after reset", rd, 32'h0);
        wb_write(`FPU_REG_A, 32'h13579bdf);
        wb_write(`FPU_REG_B, 32'h2468ace0);
        wb_read(`FPU_REG_A, rd);
        check_value("A readback", rd, 32'h13579bdf);
        wb_read(`FPU_REG_B, rd);
        check_value("B readback", rd, 32'h2468ace0);

        foreach (vecs[i])
            run_op(vecs[i]);

        for (int n = 0; n < N_RANDOM; n++) begin
            v.a = $urandom();
            rnd = $urandom() % 32'd4;
            if (rnd == 32'd0)
                v.b = v.a;               // equal operands
            else if (rnd == 32'd1)
                v.b = v.a ^ 32'h80000000; // same magnitude with the other sign
            else
                v.b = $urandom();
            rnd  = $urandom() % 32'd3;
            v.op = rnd[1:0] + 2'd1;       // eq, lt or le
            v.expected = {31'b0, compare_model(v.a, v.b, v.op)};
            run_op(v);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/fpu_pkg.sv
src/fp_op_if.sv
src/fpu_wb_regs.sv
src/fp_add_align.sv
src/fp_normalize.sv
src/fp_compare.sv
src/fpu_exec.sv
src/fpu_top.sv
sim/tb_clkgen.sv
sim/tb_fpu.sv

//--- src/fp_add_align.sv
`default_nettype none

`include "fpu_defines.svh"

module fp_add_align (
    input  logic                   clk,
    input  logic                   load,
    input  fpu_pkg::fp32_t         a,
    input  fpu_pkg::fp32_t         b,
    output logic                   sum_sign,
    output logic [`FPU_EXP_W-1:0]  sum_exp,
    output logic [`FPU_MANT_W+1:0] sum_mant,
    output logic                   sum_zero
);

    logic                   a_big;    // |a| >= |b|
    fpu_pkg::fp32_t         big;      // larger magnitude operand
    fpu_pkg::fp32_t         smaller;  // smaller magnitude operand
    logic [`FPU_EXP_W-1:0]  exp_diff; // never negative since big is larger
    logic [`FPU_MANT_W:0]   big_m;    // 1.mant of big
    logic [`FPU_MANT_W:0]   small_m;  // 1.mant of smaller, then aligned
    logic [`FPU_MANT_W+1:0] raw;      // carry + hidden + fraction

    // exponent-then-mantissa as one unsigned number gives magnitude order
    assign a_big = {a.exp, a.mant} >= {b.exp, b.mant};

    always_comb begin
        if (a_big) begin
            big     = a;
            smaller = b;
        end else begin
            big     = b;
            smaller = a;
        end
    end

    assign exp_diff = big.exp - smaller.exp;
    assign big_m    = {1'b1, big.mant};                  // hidden one back
    assign small_m  = {1'b1, smaller.mant} >> exp_diff;  // bits shifted out are lost

    // like signs add and unlike signs subtract small from big
    always_comb begin
        if (a.sign == b.sign)
            raw = {1'b0, big_m} + {1'b0, small_m};
        else
            raw = {1'b0, big_m} - {1'b0, small_m};     // no borrow since big >= small
    end

    // raw sum registered for the normalizer
    always_ff @(posedge clk) begin
        if (load) begin
            sum_sign <= big.sign;   // sign follows larger magnitude
            sum_exp  <= big.exp;    // normalizer adjusts from here
            sum_mant <= raw;
            sum_zero <= (raw == '0); // only on exact cancellation
        end
    end

endmodule

`default_nettype wire

//--- src/fp_compare.sv
`default_nettype none

module fp_compare (
    input  fpu_pkg::fp32_t   a,
    input  fpu_pkg::fp32_t   b,
    input  fpu_pkg::fpu_op_e op,
    output logic             flag
);

    logic eq;      // bitwise equal
    logic mag_lt;  // |a| < |b|
    logic mag_gt;  // |a| > |b|
    logic mag_eq;  // same exp and mant
    logic lt;
    logic le;

    assign eq     = (a == b);
    assign mag_lt = {a.exp, a.mant} < {b.exp, b.mant};  // exp first, then mant
    assign mag_gt = {a.exp, a.mant} > {b.exp, b.mant};
    assign mag_eq = ~mag_lt & ~mag_gt;

    always_comb begin
        if (a.sign != b.sign) begin
            lt = a.sign; // negative a is the smaller one
            le = a.sign;
        end else if (!a.sign) begin
            lt = mag_lt;            // both positive
            le = mag_lt | mag_eq;
        end else begin
            lt = mag_gt;            // both negative, order reversed
            le = mag_gt | mag_eq;
        end
    end

    always_comb begin
        case (op)
            fpu_pkg::op_eq: flag = eq;
            fpu_pkg::op_lt: flag = lt;
            fpu_pkg::op_le: flag = le;
            default:        flag = 1'b0; // add has no flag
        endcase
    end

endmodule

`default_nettype wire

//--- src/fp_normalize.sv
`default_nettype none

`include "fpu_defines.svh"

module fp_normalize (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   raw_sign,
    input  logic [`FPU_EXP_W-1:0]  raw_exp,
    input  logic [`FPU_MANT_W+1:0] raw_mant,
    input  logic                   raw_zero,
    output fpu_pkg::fp32_t         result,
    output logic                   ready
);

    logic                  busy_q;  // left-shift loop running
    logic                  sign_q;
    logic [`FPU_EXP_W-1:0] exp_q;
    logic [`FPU_MANT_W:0]  mant_q;  // hidden bit at msb

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            ready  <= 1'b0;
        end else begin
            ready <= 1'b0; // pulse
            if (start) begin
                if (raw_zero || raw_mant[`FPU_MANT_W+1] || raw_mant[`FPU_MANT_W])
                    ready <= 1'b1;  // already in shape after one cycle
                else
                    busy_q <= 1'b1; // needs left shifts
            end else if (busy_q && mant_q[`FPU_MANT_W-1]) begin
                busy_q <= 1'b0; // hidden bit lands with this shift
                ready  <= 1'b1;
            end
        end
    end

    // sign, exponent and mantissa being normalized
    always_ff @(posedge clk) begin
        if (start) begin
            if (raw_zero) begin
                sign_q <= 1'b0; // cancellation gives +0
                exp_q  <= '0;
                mant_q <= '0;
            end else if (raw_mant[`FPU_MANT_W+1]) begin
                sign_q <= raw_sign;
                exp_q  <= raw_exp + 1'b1;                 // carry out
                mant_q <= raw_mant[`FPU_MANT_W+1:1];      // lsb truncated
            end else begin
                sign_q <= raw_sign;
                exp_q  <= raw_exp;
                mant_q <= raw_mant[`FPU_MANT_W:0];
            end
        end else if (busy_q) begin
            mant_q <= mant_q << 1; // one bit per cycle
            exp_q  <= exp_q - 1'b1;
        end
    end

    // hidden bit dropped on the way out
    assign result.sign = sign_q;
    assign result.exp  = exp_q;
    assign result.mant = mant_q[`FPU_MANT_W-1:0];

endmodule

`default_nettype wire

//--- src/fp_op_if.sv
`default_nettype none

// operation channel between register block and execution unit
interface fp_op_if;

    fpu_pkg::fp32_t   a;      // operand a, held until done
    fpu_pkg::fp32_t   b;      // operand b, held until done
    fpu_pkg::fpu_op_e op;     // operation select
    logic             start;  // one-cycle pulse, only while !busy
    logic             busy;   // exec unit occupied
    logic             done;   // one-cycle pulse
    fpu_pkg::fp32_t   result; // add result, valid on done
    logic             flag;   // compare flag, valid on done

    modport regs (
        output a,
        output b,
        output op,
        output start,
        input  busy,
        input  done,
        input  result,
        input  flag
    );

    modport exec (
        input  a,
        input  b,
        input  op,
        input  start,
        output busy,
        output done,
        output result,
        output flag
    );

endinterface

`default_nettype wire

//--- src/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// word and field widths of one single-precision float
`define FPU_DATA_W 32     // bus word and operand width
`define FPU_EXP_W  8      // biased exponent
`define FPU_MANT_W 23     // stored mantissa, hidden one not included

// wishbone word address width
`define FPU_ADR_W  3

// register word addresses
`define FPU_REG_A    3'd0 // operand a, rw
`define FPU_REG_B    3'd1 // operand b, rw
`define FPU_REG_CTRL 3'd2 // op code in [1:0], write starts
`define FPU_REG_STAT 3'd3 // [0] busy, [1] compare flag, ro
`define FPU_REG_RES  3'd4 // last add result, ro

`endif

//--- src/fpu_exec.sv
`default_nettype none

`include "fpu_defines.svh"

module fpu_exec (
    input  logic  clk,
    input  logic  rst_n,
    fp_op_if.exec op
);

    fpu_pkg::exec_state_e state;

    logic                   load;       // capture into align stage
    logic                   norm_start; // kick normalizer
    logic                   norm_ready;
    logic                   cmp_flag;   // combinational compare out
    logic                   flag_q;
    logic                   done_q;
    logic                   sum_sign;
    logic [`FPU_EXP_W-1:0]  sum_exp;
    logic [`FPU_MANT_W+1:0] sum_mant;
    logic                   sum_zero;

    assign load = (state == fpu_pkg::st_idle) && op.start && (op.op == fpu_pkg::op_add);
    assign norm_start = (state == fpu_pkg::st_align); // align output valid now

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= fpu_pkg::st_idle;
            flag_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0; // pulse
            case (state)
                fpu_pkg::st_idle: begin
                    if (op.start) begin
                        if (op.op == fpu_pkg::op_add) begin
                            state <= fpu_pkg::st_align;
                        end else begin
                            flag_q <= cmp_flag; // operands stable, sample now
                            state  <= fpu_pkg::st_done;
                        end
                    end
                end
                fpu_pkg::st_align: state <= fpu_pkg::st_norm;
                fpu_pkg::st_norm:  if (norm_ready) state <= fpu_pkg::st_done;
                fpu_pkg::st_done: begin
                    done_q <= 1'b1;
                    state  <= fpu_pkg::st_idle;
                end
                default: state <= fpu_pkg::st_idle;
            endcase
        end
    end

    fp_compare i_compare (
        .a    (op.a),
        .b    (op.b),
        .op   (op.op),
        .flag (cmp_flag)
    );

    fp_add_align i_align (
        .clk      (clk),
        .load     (load),
        .a        (op.a),
        .b        (op.b),
        .sum_sign (sum_sign),
        .sum_exp  (sum_exp),
        .sum_mant (sum_mant),
        .sum_zero (sum_zero)
    );

    // result held in normalizer registers until the next add
    fp_normalize i_norm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (norm_start),
        .raw_sign (sum_sign),
        .raw_exp  (sum_exp),
        .raw_mant (sum_mant),
        .raw_zero (sum_zero),
        .result   (op.result),
        .ready    (norm_ready)
    );

    assign op.flag = flag_q;
    assign op.done = done_q;
    assign op.busy = (state != fpu_pkg::st_idle) | done_q; // covers the done cycle too

endmodule

`default_nettype wire

//--- src/fpu_pkg.sv
`default_nettype none

`include "fpu_defines.svh"

package fpu_pkg;

    // ieee754 single layout with sign at the msb
    typedef struct packed {
        logic                   sign; // 1 = negative
        logic [`FPU_EXP_W-1:0]  exp;  // biased by 127
        logic [`FPU_MANT_W-1:0] mant; // fraction bits only
    } fp32_t;

    // alu control codes
    typedef enum logic [1:0] {
        op_add = 2'd0, // single add
        op_eq  = 2'd1, // bitwise equal
        op_lt  = 2'd2, // less than
        op_le  = 2'd3  // less or equal
    } fpu_op_e;

    // execution sequencer
    typedef enum logic [1:0] {
        st_idle  = 2'd0, // waiting for start
        st_align = 2'd1, // align/add result being registered
        st_norm  = 2'd2, // normalizer shifting
        st_done  = 2'd3  // raise done next cycle
    } exec_state_e;

endpackage

`default_nettype wire

//--- src/fpu_top.sv
`default_nettype none

`include "fpu_defines.svh"

module fpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`FPU_ADR_W-1:0]  wb_adr,
    input  logic [`FPU_DATA_W-1:0] wb_dat_i,
    output logic [`FPU_DATA_W-1:0] wb_dat_o,
    output logic                   wb_ack
);

    fp_op_if i_op_if (); // regs <-> exec channel

    fpu_wb_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .op       (i_op_if.regs)
    );

    fpu_exec i_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (i_op_if.exec)
    );

endmodule

`default_nettype wire

//--- src/fpu_wb_regs.sv
`default_nettype none

`include "fpu_defines.svh"

module fpu_wb_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`FPU_ADR_W-1:0]  wb_adr,
    input  logic [`FPU_DATA_W-1:0] wb_dat_i,
    output logic [`FPU_DATA_W-1:0] wb_dat_o,
    output logic                   wb_ack,
    fp_op_if.regs                  op
);

    logic                   req;     // new request, not yet acked
    logic                   wr;      // write strobe for this request
    logic                   idle;    // unit free to take a start
    logic [`FPU_DATA_W-1:0] rd_data; // read mux out

    fpu_pkg::fp32_t   a_q;     // operand registers
    fpu_pkg::fp32_t   b_q;
    fpu_pkg::fpu_op_e op_q;    // stored op code
    logic             start_q; // start pulse
    logic             busy_q;  // stat bit 0
    logic             flag_q;  // stat bit 1
    fpu_pkg::fp32_t   res_q;   // last add result

    assign req  = wb_cyc & wb_stb & ~wb_ack; // ack cycle itself is not a new request
    assign wr   = req & wb_we;
    assign idle = ~busy_q & ~op.busy;        // both sides agree unit is free

    // read mux, unmapped reads zero
    always_comb begin
        case (wb_adr)
            `FPU_REG_A:    rd_data = a_q;
            `FPU_REG_B:    rd_data = b_q;
            `FPU_REG_CTRL: rd_data = {{(`FPU_DATA_W-2){1'b0}}, op_q};
            `FPU_REG_STAT: rd_data = {{(`FPU_DATA_W-2){1'b0}}, flag_q, busy_q};
            `FPU_REG_RES:  rd_data = res_q;
            default:       rd_data = '0;
        endcase
    end

    // bus side, ack exactly one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack <= req;
            if (req && !wb_we)
                wb_dat_o <= rd_data; // held through the ack cycle
        end
    end

    // register file and start/done handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q     <= '0;
            b_q     <= '0;
            op_q    <= fpu_pkg::op_add;
            start_q <= 1'b0;
            busy_q  <= 1'b0;
            flag_q  <= 1'b0;
            res_q   <= '0;
        end else begin
            start_q <= 1'b0; // pulse only
            if (wr && idle) begin // operands frozen while an op runs
                case (wb_adr)
                    `FPU_REG_A: a_q <= wb_dat_i;
                    `FPU_REG_B: b_q <= wb_dat_i;
                    `FPU_REG_CTRL: begin
                        op_q    <= fpu_pkg::fpu_op_e'(wb_dat_i[1:0]);
                        start_q <= 1'b1;
                        busy_q  <= 1'b1; // visible on the very next stat read
                    end
                    default: ; // ro or unmapped
                endcase
            end
            if (op.done) begin
                busy_q <= 1'b0;
                if (op_q == fpu_pkg::op_add)
                    res_q <= op.result; // compares leave res alone
                else
                    flag_q <= op.flag;
            end
        end
    end

    assign op.a     = a_q;
    assign op.b     = b_q;
    assign op.op    = op_q;
    assign op.start = start_q;

endmodule

`default_nettype wire
